// File: rtl/agc_word_pkg.sv
// word layout and central register addresses; memory is 1024 words, so addresses wrap at 10 bits
package agc_word_pkg;

  // stored word is 15 data bits plus the overflow bit 15
  localparam int WORD_W     = 16;
  localparam int DATA_W     = 15;

  localparam int MEM_DEPTH  = 1024;
  localparam int MEM_ADDR_W = 10;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

  // central registers are mapped into erasable memory
  localparam mem_addr_t ADDR_A = 10'd0;
  localparam mem_addr_t ADDR_L = 10'd1;
  localparam mem_addr_t ADDR_Q = 10'd2;
  localparam mem_addr_t ADDR_Z = 10'd5;

endpackage

// File: rtl/agc_isa_pkg.sv
// basic instruction subset only; extracodes, INDEX and the I/O channel instructions are not encoded
package agc_isa_pkg;

  // opcode field, bits 14:12
  localparam logic [2:0] OP_TC   = 3'd0;
  localparam logic [2:0] OP_TCF  = 3'd1;
  // quarter-code group holding INCR
  localparam logic [2:0] OP_INCR = 3'd2;
  localparam logic [2:0] OP_CA   = 3'd3;
  localparam logic [2:0] OP_CS   = 3'd4;
  // quarter-code group holding TS and XCH
  localparam logic [2:0] OP_TS   = 3'd5;
  localparam logic [2:0] OP_AD   = 3'd6;
  localparam logic [2:0] OP_MASK = 3'd7;

  localparam logic [1:0] QC_TS   = 2'd2;
  localparam logic [1:0] QC_XCH  = 2'd3;
  localparam logic [1:0] QC_INCR = 2'd2;

  // the same word seen with a 12-bit k or with a quarter code and 10-bit k
  typedef union packed {
    struct packed {
      logic       spare;
      logic [2:0] opcode;
      logic [11:0] k;
    } basic;
    struct packed {
      logic                   spare;
      logic [2:0]             opcode;
      logic [1:0]             qc;
      agc_word_pkg::mem_addr_t k10;
    } quarter;
  } instr_u;

  typedef enum logic [2:0] {
    ALU_PASS,
    ALU_ADD,
    ALU_COM,
    ALU_AND,
    ALU_INCR
  } alu_op_e;

endpackage

// File: rtl/agc_mem_bus_if.sv
// strobes are single cycle and memory never stalls; read data is valid one cycle after the request
`timescale 1ns/10ps

interface agc_mem_bus_if
(
  input logic raw_clk
);
  import agc_word_pkg::*;

  mem_addr_t address;
  word_t     write_data;
  word_t     read_data;
  logic      bus_enable;
  logic      write_enable;

  // sequencer side
  modport requester
  (
    input  raw_clk,
    output address,
    output write_data,
    output bus_enable,
    output write_enable,
    input  read_data
  );

  // memory side
  modport responder
  (
    input  raw_clk,
    input  address,
    input  write_data,
    input  bus_enable,
    input  write_enable,
    output read_data
  );

endinterface

// File: rtl/agc_alu.sv
// purely combinational; the overflow bit 15 of the inputs is ignored except by increment
`timescale 1ns/10ps

module agc_alu
(
  input  agc_isa_pkg::alu_op_e op,
  input  agc_word_pkg::word_t  acc,
  input  agc_word_pkg::word_t  operand,
  output agc_word_pkg::word_t  result
);
  import agc_word_pkg::*;
  import agc_isa_pkg::*;

  logic [DATA_W:0]   raw_sum;
  logic [DATA_W-1:0] eac_sum;
  logic              overflow;

  // ones' complement add, carry out folded back into bit 0
  assign raw_sum  = {1'b0, acc[DATA_W-1:0]} + {1'b0, operand[DATA_W-1:0]};
  assign eac_sum  = raw_sum[DATA_W-1:0] + {{(DATA_W-1){1'b0}}, raw_sum[DATA_W]};

  // same input signs but a different result sign
  assign overflow = (acc[DATA_W-1] == operand[DATA_W-1]) &&
                    (eac_sum[DATA_W-1] != acc[DATA_W-1]);

  always_comb
  begin
    case (op)
      ALU_ADD:  result = {overflow, eac_sum};
      ALU_COM:  result = {1'b0, ~operand[DATA_W-1:0]};
      ALU_AND:  result = {1'b0, acc[DATA_W-1:0] & operand[DATA_W-1:0]};
      ALU_INCR: result = operand + word_t'(1);
      default:  result = operand;
    endcase
  end

endmodule

// File: rtl/agc_erasable_memory.sv
// the load port is ignored while run is high; the array itself is not cleared by reset
`timescale 1ns/10ps

module agc_erasable_memory
(
  input  logic                    raw_clk,
  input  logic                    button_reset,
  input  logic                    run,
  agc_mem_bus_if.responder        bus,
  input  logic                    load_enable,
  input  agc_word_pkg::mem_addr_t load_address,
  input  agc_word_pkg::word_t     load_data,
  output agc_word_pkg::word_t     reg_a,
  output agc_word_pkg::word_t     reg_z
);
  import agc_word_pkg::*;

  word_t     mem [MEM_DEPTH];
  logic      load_write;
  logic      write_strobe;
  mem_addr_t write_address;
  word_t     write_word;

  // loader wins over the bus only while the core is stopped
  assign load_write    = load_enable && !run;
  assign write_strobe  = load_write || (bus.bus_enable && bus.write_enable);
  assign write_address = load_write ? load_address : bus.address;
  assign write_word    = load_write ? load_data : bus.write_data;

  always_ff @(posedge raw_clk)
  begin
    if (write_strobe)
      mem[write_address] <= write_word;
    if (bus.bus_enable && !bus.write_enable)
      bus.read_data <= mem[bus.address];
  end

  // shadow copies of A and Z, tracking every write to their addresses
  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      reg_a <= '0;
      reg_z <= '0;
    end
    else if (write_strobe)
    begin
      if (write_address == ADDR_A)
        reg_a <= write_word;
      if (write_address == ADDR_Z)
        reg_z <= write_word;
    end
  end

endmodule

// File: rtl/agc_sequencer.sv
// one instruction in flight, no skips or interrupts; TC always saves Z into Q, TS never skips
`timescale 1ns/10ps

module agc_sequencer
(
  input  logic                 raw_clk,
  input  logic                 button_reset,
  input  logic                 run,
  agc_mem_bus_if.requester     bus,
  input  agc_word_pkg::word_t  reg_a,
  input  agc_word_pkg::word_t  reg_z,
  output agc_isa_pkg::alu_op_e alu_op,
  output agc_word_pkg::word_t  alu_acc,
  output agc_word_pkg::word_t  alu_operand,
  input  agc_word_pkg::word_t  alu_result,
  output logic                 retire
);
  import agc_word_pkg::*;
  import agc_isa_pkg::*;

  typedef enum logic [3:0] {
    S_IDLE, S_FETCH, S_CAPTURE, S_ZW0, S_ZW1, S_DECODE, S_READ0, S_READ1,
    S_EXEC, S_CARRY, S_TCQ0, S_TCQ1, S_XW0, S_XW1, S_WB0, S_RETIRE
  } state_e;

  state_e    state;
  instr_u    instr;
  word_t     temp;
  mem_addr_t wb_addr;
  alu_op_e   alu_op_q;
  logic      is_xch;

  assign is_xch = (instr.quarter.opcode == OP_TS) && (instr.quarter.qc == QC_XCH);

  assign alu_op      = alu_op_q;
  assign alu_acc     = reg_a;
  assign alu_operand = temp;
  assign retire      = (state == S_RETIRE);

  // bus requests are decoded straight from the state
  always_comb
  begin
    bus.bus_enable   = 1'b0;
    bus.write_enable = 1'b0;
    bus.address      = '0;
    bus.write_data   = '0;
    case (state)
      S_FETCH:
      begin
        bus.bus_enable = 1'b1;
        bus.address    = reg_z[MEM_ADDR_W-1:0];
      end
      S_ZW0:
      begin
        bus.bus_enable   = 1'b1;
        bus.write_enable = 1'b1;
        bus.address      = ADDR_Z;
        bus.write_data   = reg_z + word_t'(1);
      end
      S_READ0:
      begin
        bus.bus_enable = 1'b1;
        bus.address    = instr.quarter.k10;
      end
      // reg_z already holds the incremented return address here
      S_TCQ0:
      begin
        bus.bus_enable   = 1'b1;
        bus.write_enable = 1'b1;
        bus.address      = ADDR_Q;
        bus.write_data   = reg_z;
      end
      S_XW0:
      begin
        bus.bus_enable   = 1'b1;
        bus.write_enable = 1'b1;
        bus.address      = instr.quarter.k10;
        bus.write_data   = reg_a;
      end
      S_WB0:
      begin
        bus.bus_enable   = 1'b1;
        bus.write_enable = 1'b1;
        bus.address      = wb_addr;
        bus.write_data   = temp;
      end
      default:
      begin
      end
    endcase
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
      state <= S_IDLE;
    else
    begin
      case (state)
        S_IDLE:
          if (run)
            state <= S_FETCH;
        S_FETCH:   state <= S_CAPTURE;
        S_CAPTURE:
        begin
          instr <= bus.read_data;
          state <= S_ZW0;
        end
        S_ZW0:     state <= S_ZW1;
        S_ZW1:     state <= S_DECODE;
        S_DECODE:
        begin
          case (instr.basic.opcode)
            OP_TC, OP_TCF:
            begin
              temp    <= word_t'(instr.basic.k);
              wb_addr <= ADDR_Z;
              state   <= (instr.basic.opcode == OP_TC) ? S_TCQ0 : S_WB0;
            end
            OP_INCR:
            begin
              alu_op_q <= ALU_INCR;
              wb_addr  <= instr.quarter.k10;
              // other quarter codes only advance Z
              state    <= (instr.quarter.qc == QC_INCR) ? S_READ0 : S_RETIRE;
            end
            OP_TS:
            begin
              temp <= reg_a;
              if (instr.quarter.qc == QC_TS)
              begin
                wb_addr <= instr.quarter.k10;
                state   <= S_WB0;
              end
              else if (instr.quarter.qc == QC_XCH)
              begin
                wb_addr <= ADDR_A;
                state   <= S_READ0;
              end
              else
                state <= S_RETIRE;
            end
            default:
            begin
              // CA, CS, AD and MASK all land in A
              case (instr.basic.opcode)
                OP_CS:   alu_op_q <= ALU_COM;
                OP_AD:   alu_op_q <= ALU_ADD;
                OP_MASK: alu_op_q <= ALU_AND;
                default: alu_op_q <= ALU_PASS;
              endcase
              wb_addr <= ADDR_A;
              state   <= S_READ0;
            end
          endcase
        end
        S_READ0:   state <= S_READ1;
        S_READ1:
        begin
          temp  <= bus.read_data;
          state <= is_xch ? S_XW0 : S_EXEC;
        end
        S_EXEC:
        begin
          // the add gets a second cycle for its carry chain
          if (alu_op_q == ALU_ADD)
            state <= S_CARRY;
          else
          begin
            temp  <= alu_result;
            state <= S_WB0;
          end
        end
        S_CARRY:
        begin
          temp  <= alu_result;
          state <= S_WB0;
        end
        S_TCQ0:    state <= S_TCQ1;
        S_TCQ1:    state <= S_WB0;
        S_XW0:     state <= S_XW1;
        S_XW1:     state <= S_WB0;
        S_WB0:     state <= S_RETIRE;
        S_RETIRE:  state <= run ? S_FETCH : S_IDLE;
        default:   state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: rtl/agc_core.sv
// program must be loaded while run is low, Z included; only A and Z are visible outside
`timescale 1ns/10ps

module agc_core
(
  input  logic                    raw_clk,
  input  logic                    button_reset,
  input  logic                    run,
  input  logic                    load_enable,
  input  agc_word_pkg::mem_addr_t load_address,
  input  agc_word_pkg::word_t     load_data,
  output logic                    retire,
  output agc_word_pkg::word_t     reg_a,
  output agc_word_pkg::word_t     reg_z
);
  import agc_word_pkg::*;
  import agc_isa_pkg::*;

  alu_op_e alu_op;
  word_t   alu_acc;
  word_t   alu_operand;
  word_t   alu_result;

  agc_mem_bus_if bus (.raw_clk(raw_clk));

  agc_sequencer u_sequencer
  (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .run          (run),
    .bus          (bus.requester),
    .reg_a        (reg_a),
    .reg_z        (reg_z),
    .alu_op       (alu_op),
    .alu_acc      (alu_acc),
    .alu_operand  (alu_operand),
    .alu_result   (alu_result),
    .retire       (retire)
  );

  agc_erasable_memory u_memory
  (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .run          (run),
    .bus          (bus.responder),
    .load_enable  (load_enable),
    .load_address (load_address),
    .load_data    (load_data),
    .reg_a        (reg_a),
    .reg_z        (reg_z)
  );

  agc_alu u_alu
  (
    .op      (alu_op),
    .acc     (alu_acc),
    .operand (alu_operand),
    .result  (alu_result)
  );

endmodule

// File: test/agc_core_sva.sv
// bound into agc_core on raw_clk; a load write while run is low may also move Z
`timescale 1ns/10ps

module agc_core_sva
(
  input logic                raw_clk,
  input logic                button_reset,
  input logic                run,
  input logic                retire,
  input agc_word_pkg::word_t reg_z,
  input logic                seq_write,
  input logic                load_write
);

  // nothing completes in reset or before the core is started
  retire_quiet_in_reset: assert property (@(posedge raw_clk) !button_reset |=> !retire)
    else $error("retire high in the cycle after a reset cycle");

  retire_quiet_when_stopped: assert property (@(posedge raw_clk)
    (button_reset && !run) |-> !retire)
    else $error("retire high while run is low");

  // one instruction in flight, so retire is a single-cycle pulse
  retire_single_pulse: assert property (@(posedge raw_clk) disable iff (!button_reset)
    retire |=> !retire)
    else $error("retire high for two cycles in a row");

  // Z lives in memory, it only moves on a write strobe
  z_moves_on_write: assert property (@(posedge raw_clk) disable iff (!button_reset)
    (reg_z != $past(reg_z)) |-> $past(seq_write || load_write))
    else $error("reg_z changed without a memory write");

endmodule

bind agc_core agc_core_sva u_sva
(
  .raw_clk      (raw_clk),
  .button_reset (button_reset),
  .run          (run),
  .retire       (retire),
  .reg_z        (reg_z),
  .seq_write    (bus.bus_enable && bus.write_enable),
  .load_write   (load_enable && !run)
);

// File: test/agc_core_tb.sv
// program in 8..199 ends in a TCF back to 8; stores avoid Z, so control flow stays in the program
`timescale 1ns/10ps

module agc_core_tb;
  import agc_word_pkg::*;
  import agc_isa_pkg::*;

  localparam int          NUM_INSTR    = 300;
  localparam int          RESET_CYCLES = 16;
  localparam int          CYCLE_LIMIT  = NUM_INSTR * 16 + 256 + RESET_CYCLES + 16;
  localparam logic [15:0] SEED         = 16'd48058;
  localparam mem_addr_t   PROG_FIRST   = 10'd8;
  localparam mem_addr_t   PROG_LAST    = 10'd199;
  localparam mem_addr_t   LAST_LOADED  = 10'd255;

  logic        raw_clk;
  logic        button_reset;
  logic        run;
  logic        load_enable;
  mem_addr_t   load_address;
  word_t       load_data;
  logic        retire;
  word_t       reg_a;
  word_t       reg_z;
  logic [15:0] lfsr;
  word_t       model [MEM_DEPTH];
  int          errors;
  int          retired;
  int          cycle_count;

  agc_core DUT
  (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .run          (run),
    .load_enable  (load_enable),
    .load_address (load_address),
    .load_data    (load_data),
    .retire       (retire),
    .reg_a        (reg_a),
    .reg_z        (reg_z)
  );

  always #20 raw_clk = ~raw_clk;

  // Galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    lfsr_next = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  task automatic draw_bits(input int width, output logic [15:0] value);
    int i;
    value = '0;
    for (i = 0; i < width; i++)
    begin
      lfsr  = lfsr_next(lfsr);
      value = {value[14:0], lfsr[0]};
    end
  endtask

  // either 0..7 except Z or 200..255
  task automatic pick_store_address(output mem_addr_t addr);
    logic [15:0] r;
    draw_bits(7, r);
    if (r[6])
      addr = 10'd200 + mem_addr_t'(r[5:0] % 6'd56);
    else if (r[2:0] == 3'd5)
      addr = 10'd6;
    else
      addr = {7'd0, r[2:0]};
  endtask

  task automatic make_instruction(output word_t ins);
    logic [15:0] r;
    logic        spare;
    logic [2:0]  opcode;
    logic [1:0]  qc;
    mem_addr_t   addr;
    draw_bits(4, r);
    spare  = r[3];
    opcode = r[2:0];
    case (opcode)
      OP_TC, OP_TCF:
      begin
        draw_bits(8, r);
        ins = {spare, opcode, 2'b00, PROG_FIRST + mem_addr_t'(r[7:0] % 8'd192)};
      end
      OP_INCR, OP_TS:
      begin
        draw_bits(2, r);
        qc = r[1:0];
        pick_store_address(addr);
        ins = {spare, opcode, qc, addr};
      end
      default:
      begin
        // bits 11:10 of k are dropped by the address wrap
        draw_bits(10, r);
        ins = {spare, opcode, r[9:8], 2'b00, r[7:0]};
      end
    endcase
  endtask

  function automatic word_t ones_add(input word_t a, input word_t b);
    int   sum;
    logic ovf;
    sum = int'(a[14:0]) + int'(b[14:0]);
    // a carry out of bit 14 re-enters at bit 0
    if (sum > 32767)
      sum = sum - 32767;
    ovf      = (a[14] == b[14]) && (sum[14] != a[14]);
    ones_add = {ovf, sum[14:0]};
  endfunction

  // Z advances before the operand is read
  task automatic model_step(output word_t ins);
    word_t      operand;
    logic [2:0] opcode;
    logic [1:0] qc;
    mem_addr_t  k10;
    ins           = model[model[ADDR_Z][9:0]];
    model[ADDR_Z] = model[ADDR_Z] + 16'd1;
    opcode        = ins[14:12];
    qc            = ins[11:10];
    k10           = ins[9:0];
    operand       = model[k10];
    case (opcode)
      OP_TC:
      begin
        model[ADDR_Q] = model[ADDR_Z];
        model[ADDR_Z] = {4'd0, ins[11:0]};
      end
      OP_TCF:
        model[ADDR_Z] = {4'd0, ins[11:0]};
      OP_INCR:
        if (qc == QC_INCR)
          model[k10] = operand + 16'd1;
      OP_CA:
        model[ADDR_A] = operand;
      OP_CS:
        model[ADDR_A] = {1'b0, ~operand[14:0]};
      OP_TS:
        if (qc == QC_TS)
          model[k10] = model[ADDR_A];
        else if (qc == QC_XCH)
        begin
          model[k10]    = model[ADDR_A];
          model[ADDR_A] = operand;
        end
      OP_AD:
        model[ADDR_A] = ones_add(model[ADDR_A], operand);
      default:
        model[ADDR_A] = {1'b0, model[ADDR_A][14:0] & operand[14:0]};
    endcase
  endtask

  task automatic check_state(input word_t ins);
    assert (reg_z === model[ADDR_Z])
    else
    begin
      errors++;
      $display("ERR %0t: Z is %h, expected %h after instruction %h",
               $time, reg_z, model[ADDR_Z], ins);
    end
    assert (reg_a === model[ADDR_A])
    else
    begin
      errors++;
      $display("ERR %0t: A is %h, expected %h after instruction %h",
               $time, reg_a, model[ADDR_A], ins);
    end
  endtask

  initial
  begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT)
    begin
      @(posedge raw_clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the processor stopped retiring", cycle_count);
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    word_t     image_word;
    word_t     ins;
    mem_addr_t addr;
    raw_clk      = 1'b0;
    button_reset = 1'b0;
    run          = 1'b0;
    load_enable  = 1'b0;
    load_address = '0;
    load_data    = '0;
    lfsr         = SEED;
    errors       = 0;
    retired      = 0;
    repeat (RESET_CYCLES) @(negedge raw_clk);
    button_reset = 1'b1;

    // random data around the program
    for (addr = '0; addr <= LAST_LOADED; addr++)
    begin
      if (addr >= PROG_FIRST && addr < PROG_LAST)
        make_instruction(image_word);
      else
        draw_bits(16, image_word);
      model[addr] = image_word;
    end
    model[ADDR_Z]    = {6'd0, PROG_FIRST};
    model[PROG_LAST] = {1'b0, OP_TCF, 2'b00, PROG_FIRST};

    for (addr = '0; addr <= LAST_LOADED; addr++)
    begin
      load_enable  = 1'b1;
      load_address = addr;
      load_data    = model[addr];
      @(negedge raw_clk);
    end
    load_enable = 1'b0;
    run         = 1'b1;

    while (retired < NUM_INSTR)
    begin
      @(negedge raw_clk);
      if (retire)
      begin
        model_step(ins);
        check_state(ins);
        retired++;
      end
    end

    $display("checked %0d instructions, %0d errors", retired, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// File: agc_core.f
rtl/agc_word_pkg.sv
rtl/agc_isa_pkg.sv
rtl/agc_mem_bus_if.sv
rtl/agc_alu.sv
rtl/agc_erasable_memory.sv
rtl/agc_sequencer.sv
rtl/agc_core.sv
test/agc_core_sva.sv
test/agc_core_tb.sv

// File: Makefile
TOP := agc_core_tb
BUILD := build

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD) -f agc_core.f
	./$(BUILD)/V$(TOP) | awk '{ print } /Result: PASSED/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f agc_core.f

clean:
	rm -rf $(BUILD)
